/* hps_link_config.svh */
////////////////////////////////////////////////////////////
// host link constants shared by the package and the RTL
// command codes are compared against the low byte of the
// first word in a frame, so only 8 bits are kept
// HPS_DL_WIDE is a build choice and is not switchable at run
////////////////////////////////////////////////////////////
`ifndef HPS_LINK_CONFIG_SVH
`define HPS_LINK_CONFIG_SVH

// command codes
`define HPS_CMD_CFG        8'h01
`define HPS_CMD_JOY0       8'h02
`define HPS_CMD_JOY1       8'h03
`define HPS_CMD_KBD        8'h05
`define HPS_CMD_STATUS     8'h1e
`define HPS_CMD_STATUS_SET 8'h29
`define HPS_CMD_FILE_TX    8'h53
`define HPS_CMD_FILE_DAT   8'h54
`define HPS_CMD_FILE_INDEX 8'h55
`define HPS_CMD_FILE_INFO  8'h56

// download engine
`define HPS_DL_WIDE        1'b0
`define HPS_DL_ADDR_W      27

// payload word counter, saturating
`define HPS_WORD_CNT_W     4

`endif

/* hps_link_pkg.sv */
////////////////////////////////////////////////////////////
// types for the host link decoder
// widths of idx and addr follow the config header
////////////////////////////////////////////////////////////
`include "hps_link_config.svh"

package hps_link_pkg;

	// host side inputs, 18 bits
	typedef struct packed {
		logic        enable;
		logic        strobe;
		logic [15:0] din;
	} hps_bus_t;

	// keyboard payload view, tag ff means skip the rest of the frame
	typedef struct packed {
		logic [7:0] tag;
		logic [7:0] code;
	} scan_rec_t;

	typedef union packed {
		logic [15:0] raw;
		scan_rec_t   scan;
	} host_data_u;

	// idx 0 marks the command word itself, payload starts at 1
	typedef struct packed {
		logic                       valid;
		logic [7:0]                 cmd;
		logic [`HPS_WORD_CNT_W-1:0] idx;
		host_data_u                 data;
	} host_word_t;

	typedef struct packed {
		logic       valid;
		logic [7:0] cmd;
	} frame_end_t;

	// bits 3:2 and 7:5 are handled outside this core
	typedef struct packed {
		logic [2:0] spare_hi;
		logic       scandoubler;
		logic [1:0] spare_lo;
		logic [1:0] buttons;
	} cfg_t;

	typedef struct packed {
		logic                      download;
		logic                      wr;
		logic [7:0]                index;
		logic [`HPS_DL_ADDR_W-1:0] addr;
		logic [15:0]               dout;
		logic [31:0]               file_ext;
	} dl_t;

endpackage

/* hps_frame_decoder.sv */
////////////////////////////////////////////////////////////
// frame decoder, one cycle latency
// the command word leaves with idx 0, payload words with
// idx 1 upward, the index saturates and never wraps to 0
// frame_end follows the falling edge of enable by one cycle
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "hps_link_config.svh"

module hps_frame_decoder (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  hps_link_pkg::hps_bus_t   bus,
	output hps_link_pkg::host_word_t word,
	output hps_link_pkg::frame_end_t frame_end
);

	logic [7:0]                 cmd_q;
	logic [`HPS_WORD_CNT_W-1:0] cnt_q;
	logic                       enable_q;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cmd_q     <= '0;
			cnt_q     <= '0;
			enable_q  <= 1'b0;
			word      <= '0;
			frame_end <= '0;
		end else begin
			enable_q        <= bus.enable;
			word.valid      <= 1'b0;
			frame_end.valid <= 1'b0;

			if (!bus.enable) begin
				cnt_q <= '0;
				cmd_q <= '0;
				if (enable_q) begin
					frame_end.valid <= 1'b1;
					frame_end.cmd   <= cmd_q;
				end
			end else if (bus.strobe) begin
				word.valid    <= 1'b1;
				word.idx      <= cnt_q;
				word.data.raw <= bus.din;
				// first strobe of the frame carries the command
				if (cnt_q == '0) begin
					cmd_q    <= bus.din[7:0];
					word.cmd <= bus.din[7:0];
				end else begin
					word.cmd <= cmd_q;
				end
				if (cnt_q != '1) begin
					cnt_q <= cnt_q + 1'b1;
				end
			end
		end
	end

endmodule

/* hps_reg_block.sv */
////////////////////////////////////////////////////////////
// configuration, joystick and status registers
// registers update one cycle after the decoded word
// dout holds a reply for one cycle only, then returns to 0
// status_set is sampled on clk_sys, so it must already be
// synchronous to it and stay high for at least one cycle
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "hps_link_config.svh"

module hps_reg_block (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  hps_link_pkg::host_word_t word,
	input  logic [31:0]              status_in,
	input  logic                     status_set,
	output hps_link_pkg::cfg_t       cfg,
	output logic [31:0]              joystick_0,
	output logic [31:0]              joystick_1,
	output logic [31:0]              status,
	output logic [15:0]              dout
);

	logic [31:0] status_req;
	logic [3:0]  set_cnt;
	logic        status_set_q;

	// word 1 fills the low half, word 2 the high half
	function automatic logic [31:0] fill_half(
		input logic [31:0]                old,
		input logic [`HPS_WORD_CNT_W-1:0] idx,
		input logic [15:0]                data
	);
		logic [31:0] res;
		res = old;
		if (idx == 1) begin
			res[15:0] = data;
		end else if (idx == 2) begin
			res[31:16] = data;
		end
		return res;
	endfunction

	////////////////////////////////////////////////////////////
	// core side status request
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			status_set_q <= 1'b0;
			status_req   <= '0;
			set_cnt      <= '0;
		end else begin
			status_set_q <= status_set;
			if (status_set && !status_set_q) begin
				status_req <= status_in;
				set_cnt    <= set_cnt + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// host writes and readback
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
			dout       <= '0;
		end else begin
			dout <= '0;
			if (word.valid) begin
				case (word.cmd)
					`HPS_CMD_CFG: begin
						if (word.idx == 1) begin
							cfg <= word.data.raw[7:0];
						end
					end
					`HPS_CMD_JOY0:
						joystick_0 <= fill_half(joystick_0, word.idx, word.data.raw);
					`HPS_CMD_JOY1:
						joystick_1 <= fill_half(joystick_1, word.idx, word.data.raw);
					`HPS_CMD_STATUS:
						status <= fill_half(status, word.idx, word.data.raw);
					`HPS_CMD_STATUS_SET: begin
						// header first, then the captured request
						case (word.idx)
							0:       dout <= {8'h00, 4'ha, set_cnt};
							1:       dout <= status_req[15:0];
							2:       dout <= status_req[31:16];
							default: dout <= '0;
						endcase
					end
					default: ;
				endcase
			end
		end
	end

endmodule

/* hps_key_decoder.sv */
////////////////////////////////////////////////////////////
// keyboard event builder
// bytes of one frame form one key event, issued at frame end
// ps2_key[10] toggles per event, [9] pressed, [8] extended
// only the last four bytes are kept for prefix decoding
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "hps_link_config.svh"

module hps_key_decoder (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  hps_link_pkg::host_word_t word,
	input  hps_link_pkg::frame_end_t frame_end,
	output logic [10:0]              ps2_key
);

	logic [31:0] key_raw;
	logic        skip;
	logic        pressed;
	logic        extended;
	logic        kbd_word;

	// break prefix f0 directly before the code means release
	assign pressed  = (key_raw[15:8] != 8'hf0);
	assign extended = pressed ? (key_raw[15:8] == 8'he0) : (key_raw[23:16] == 8'he0);
	assign kbd_word = word.valid && (word.cmd == `HPS_CMD_KBD);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			key_raw <= '0;
			skip    <= 1'b0;
			ps2_key <= '0;
		end else begin
			if (kbd_word) begin
				if (word.idx == 0) begin
					key_raw <= '0;
					skip    <= 1'b0;
				end else if (word.data.scan.tag == 8'hff) begin
					skip <= 1'b1;
				end else if (!skip) begin
					key_raw <= {key_raw[23:0], word.data.scan.code};
				end
			end

			if (frame_end.valid) begin
				skip <= 1'b0;
				if (frame_end.cmd == `HPS_CMD_KBD && !skip) begin
					ps2_key <= {~ps2_key[10], pressed, extended, key_raw[7:0]};
					// print screen and pause use long sequences
					case (key_raw)
						32'he012e07c: ps2_key[9:0] <= 10'h37c;
						32'h7ce0f012: ps2_key[9:0] <= 10'h17c;
						32'hf014f077: ps2_key[9:0] <= 10'h377;
						default: ;
					endcase
				end
			end
		end
	end

endmodule

/* hps_file_loader.sv */
////////////////////////////////////////////////////////////
// file download engine
// wr pulses one cycle per data word, two cycles after strobe
// in byte mode the upper byte of dout stays zero
// ioctl_wait is not seen here, the host paces the words
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "hps_link_config.svh"

module hps_file_loader (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  hps_link_pkg::host_word_t word,
	output hps_link_pkg::dl_t        dl
);

	localparam logic [`HPS_DL_ADDR_W-1:0] addr_step = (`HPS_DL_WIDE != 0) ? 2 : 1;

	logic [`HPS_DL_ADDR_W-1:0] addr_cnt;
	logic                      payload;

	// the command word itself carries nothing for this engine
	assign payload = word.valid && (word.idx != 0);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dl       <= '0;
			addr_cnt <= '0;
		end else begin
			dl.wr <= 1'b0;
			if (payload) begin
				case (word.cmd)
					`HPS_CMD_FILE_INFO: begin
						if (word.idx == 1) begin
							dl.file_ext[31:16] <= word.data.raw;
						end else if (word.idx == 2) begin
							dl.file_ext[15:0] <= word.data.raw;
						end
					end
					`HPS_CMD_FILE_INDEX:
						dl.index <= word.data.raw[7:0];
					`HPS_CMD_FILE_TX: begin
						if (word.data.raw[7:0] != 8'h00) begin
							addr_cnt    <= '0;
							dl.download <= 1'b1;
						end else begin
							// leave the final address visible at stop
							dl.addr     <= addr_cnt;
							dl.download <= 1'b0;
						end
					end
					`HPS_CMD_FILE_DAT: begin
						dl.addr <= addr_cnt;
						dl.dout <= (`HPS_DL_WIDE != 0) ? word.data.raw
							: {8'h00, word.data.raw[7:0]};
						dl.wr    <= 1'b1;
						addr_cnt <= addr_cnt + addr_step;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

/* hps_link_top.sv */
////////////////////////////////////////////////////////////
// host link top level
// one decoder feeds every engine, each engine picks out its
// own command codes, wait_req is advisory only
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module hps_link_top (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  hps_link_pkg::hps_bus_t bus,
	output logic [15:0]            dout,
	output logic                   wait_req,
	input  logic                   ioctl_wait,
	input  logic [31:0]            status_in,
	input  logic                   status_set,
	output logic [1:0]             buttons,
	output logic                   forced_scandoubler,
	output logic [31:0]            joystick_0,
	output logic [31:0]            joystick_1,
	output logic [31:0]            status,
	output logic [10:0]            ps2_key,
	output hps_link_pkg::dl_t      dl
);

	hps_link_pkg::host_word_t word;
	hps_link_pkg::frame_end_t frame_end;
	hps_link_pkg::cfg_t       cfg;

	assign wait_req           = ioctl_wait;
	assign buttons            = cfg.buttons;
	assign forced_scandoubler = cfg.scandoubler;

	hps_frame_decoder u_hps_frame_decoder (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.bus       (bus),
		.word      (word),
		.frame_end (frame_end)
	);

	hps_reg_block u_hps_reg_block (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.word       (word),
		.status_in  (status_in),
		.status_set (status_set),
		.cfg        (cfg),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.status     (status),
		.dout       (dout)
	);

	hps_key_decoder u_hps_key_decoder (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.word      (word),
		.frame_end (frame_end),
		.ps2_key   (ps2_key)
	);

	hps_file_loader u_hps_file_loader (
		.clk_sys (clk_sys),
		.reset   (reset),
		.word    (word),
		.dl      (dl)
	);

endmodule

/* hps_link_assert.sv */
////////////////////////////////////////////////////////////
// protocol assertions for the host link top level
// frame_end is the decoder's internal end of frame pulse
// all properties are off while reset is high
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module hps_link_assert (
	input logic                     clk_sys,
	input logic                     reset,
	input hps_link_pkg::hps_bus_t   bus,
	input logic [15:0]              dout,
	input logic [10:0]              ps2_key,
	input hps_link_pkg::frame_end_t frame_end,
	input hps_link_pkg::dl_t        dl
);

	int fail_cnt = 0;

	// write strobe is a single cycle pulse
	wr_one_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		dl.wr |=> !dl.wr)
		else begin
			fail_cnt++;
			$error("download write strobe lasted more than one cycle");
		end

	wr_in_download: assert property (@(posedge clk_sys) disable iff (reset)
		dl.wr |-> dl.download)
		else begin
			fail_cnt++;
			$error("download write strobe seen outside a download");
		end

	// key event toggle follows frame end by one cycle
	key_after_frame: assert property (@(posedge clk_sys) disable iff (reset)
		(ps2_key[10] != $past(ps2_key[10])) |-> $past(frame_end.valid))
		else begin
			fail_cnt++;
			$error("key event toggle changed outside a frame end");
		end

	dout_idle_zero: assert property (@(posedge clk_sys) disable iff (reset)
		!bus.enable |-> (dout == 16'h0000))
		else begin
			fail_cnt++;
			$error("readback data nonzero while enable is low");
		end

endmodule

/* tb_hps_link.sv */
////////////////////////////////////////////////////////////
// testbench for the host link decoder
// inputs change 1 ns after each rising edge, outputs are
// sampled at the same point, after the edge has settled
// download checks follow the byte or wide build choice
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "hps_link_config.svh"

module tb_hps_link;

	localparam int clk_period = 100;
	localparam int wait_limit = 50;
	localparam int dl_words   = 8;
	localparam int addr_step  = (`HPS_DL_WIDE != 0) ? 2 : 1;

	logic                      clk_sys;
	logic                      reset;
	hps_link_pkg::hps_bus_t    bus;
	logic [15:0]               dout;
	logic                      wait_req;
	logic                      ioctl_wait;
	logic [31:0]               status_in;
	logic                      status_set;
	logic [1:0]                buttons;
	logic                      forced_scandoubler;
	logic [31:0]               joystick_0;
	logic [31:0]               joystick_1;
	logic [31:0]               status;
	logic [10:0]               ps2_key;
	hps_link_pkg::dl_t         dl;

	integer                    seed;
	int                        errors;
	int                        checks;
	logic [15:0]               frame_w [0:15];
	logic [15:0]               reply [0:15];
	logic [15:0]               dl_data [0:15];
	logic [`HPS_DL_ADDR_W-1:0] wr_addr [$];
	logic [15:0]               wr_data [$];

	hps_link_top u_hps_link_top (.*);

	bind hps_link_top hps_link_assert u_hps_link_assert (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.bus       (bus),
		.dout      (dout),
		.ps2_key   (ps2_key),
		.frame_end (frame_end),
		.dl        (dl)
	);

	initial clk_sys = 1'b0;
	always #(clk_period / 2) clk_sys = ~clk_sys;

	// every download write, in order
	always begin
		@(posedge clk_sys);
		#1;
		if (dl.wr) begin
			wr_addr.push_back(dl.addr);
			wr_data.push_back(dl.dout);
		end
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	function automatic logic [15:0] rand_word();
		logic [31:0] r;
		r = $random(seed);
		return r[15:0];
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("MISMATCH %s got %h expected %h", name, got, exp);
		end
	endtask

	// frame_w[0] is the command, reply[i] is dout two cycles after strobe i
	task automatic send_frame(input int n);
		int i;
		bus.enable = 1'b1;
		tick();
		for (i = 0; i < n; i++) begin
			bus.strobe = 1'b1;
			bus.din    = frame_w[i];
			tick();
			bus.strobe = 1'b0;
			tick();
			reply[i] = dout;
		end
		tick();
		bus.enable = 1'b0;
		tick();
		tick();
	endtask

	task automatic send_pair(input logic [7:0] cmd, output logic [31:0] val);
		frame_w[0] = {8'h00, cmd};
		frame_w[1] = rand_word();
		frame_w[2] = rand_word();
		val = {frame_w[2], frame_w[1]};
		send_frame(3);
	endtask

	task automatic wait_download(input logic level);
		int n;
		n = 0;
		while (dl.download !== level && n < wait_limit) begin
			tick();
			n++;
		end
		if (dl.download !== level) begin
			errors++;
			$display("timeout waiting for download to become %0d", level);
		end
	endtask

	task automatic wait_key_event(input logic prev);
		int n;
		n = 0;
		while (ps2_key[10] === prev && n < wait_limit) begin
			tick();
			n++;
		end
		if (ps2_key[10] === prev) begin
			errors++;
			$display("timeout waiting for a key event toggle");
		end
	endtask

	task automatic wait_writes(input int count);
		int n;
		n = 0;
		while (wr_addr.size() < count && n < wait_limit) begin
			tick();
			n++;
		end
		if (wr_addr.size() < count) begin
			errors++;
			$display("timeout waiting for %0d download writes", count);
		end
	endtask

	task automatic key_check(input int n, input logic [9:0] exp);
		logic prev;
		prev = ps2_key[10];
		frame_w[0] = {8'h00, `HPS_CMD_KBD};
		send_frame(n);
		wait_key_event(prev);
		check_value("ps2_key", {21'h0, ps2_key}, {21'h0, ~prev, exp});
	endtask

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] exp_j0;
		logic [31:0] exp_j1;
		logic [31:0] exp_st;
		logic [31:0] ext;
		logic [15:0] w;
		logic [10:0] key_prev;
		logic [7:0]  idx;
		logic [7:0]  cfg_byte;
		int          i;
		int          total;

		seed       = 32'hda56_7f74;
		errors     = 0;
		checks     = 0;
		reset      = 1'b1;
		bus        = '0;
		ioctl_wait = 1'b0;
		status_in  = '0;
		status_set = 1'b0;
		repeat (3) tick();
		reset = 1'b0;
		tick();

		check_value("dout", dout, 32'h0);
		check_value("dl.wr", dl.wr, 32'h0);
		check_value("dl.download", dl.download, 32'h0);
		check_value("ps2_key", ps2_key, 32'h0);
		check_value("buttons", buttons, 32'h0);
		check_value("status", status, 32'h0);

		ioctl_wait = 1'b1;
		tick();
		check_value("wait_req", wait_req, 32'h1);
		ioctl_wait = 1'b0;

		// configuration byte
		frame_w[0] = {8'h00, `HPS_CMD_CFG};
		frame_w[1] = rand_word();
		cfg_byte   = frame_w[1][7:0];
		send_frame(2);
		check_value("buttons", buttons, cfg_byte[1:0]);
		check_value("forced_scandoubler", forced_scandoubler, cfg_byte[4]);

		send_pair(`HPS_CMD_JOY0, exp_j0);
		check_value("joystick_0", joystick_0, exp_j0);
		check_value("joystick_1", joystick_1, 32'h0);
		send_pair(`HPS_CMD_JOY1, exp_j1);
		check_value("joystick_1", joystick_1, exp_j1);
		check_value("joystick_0", joystick_0, exp_j0);
		check_value("status", status, 32'h0);
		send_pair(`HPS_CMD_STATUS, exp_st);
		check_value("status", status, exp_st);
		check_value("joystick_0", joystick_0, exp_j0);
		check_value("joystick_1", joystick_1, exp_j1);
		check_value("buttons", buttons, cfg_byte[1:0]);
		check_value("forced_scandoubler", forced_scandoubler, cfg_byte[4]);

		// two status set requests, the reply shows the last one
		repeat (2) begin
			status_in  = {rand_word(), rand_word()};
			status_set = 1'b1;
			tick();
			status_set = 1'b0;
			tick();
		end
		frame_w[0] = {8'h00, `HPS_CMD_STATUS_SET};
		frame_w[1] = 16'h0000;
		frame_w[2] = 16'h0000;
		send_frame(3);
		check_value("dout header", reply[0], 32'h0000_00a2);
		check_value("dout low half", reply[1], status_in[15:0]);
		check_value("dout high half", reply[2], status_in[31:16]);

		// keyboard events
		frame_w[1] = 16'h001c;
		key_check(2, {1'b1, 1'b0, 8'h1c});
		frame_w[1] = 16'h00f0;
		frame_w[2] = 16'h001c;
		key_check(3, {1'b0, 1'b0, 8'h1c});
		frame_w[1] = 16'h00e0;
		frame_w[2] = 16'h00f0;
		frame_w[3] = 16'h0075;
		key_check(4, {1'b0, 1'b1, 8'h75});
		key_prev   = ps2_key;
		w          = rand_word();
		frame_w[0] = {8'h00, `HPS_CMD_KBD};
		frame_w[1] = {8'hff, w[7:0]};
		frame_w[2] = 16'h001c;
		send_frame(3);
		repeat (4) tick();
		check_value("ps2_key", ps2_key, key_prev);

		// file download
		frame_w[0] = {8'h00, `HPS_CMD_FILE_INDEX};
		frame_w[1] = rand_word();
		idx        = frame_w[1][7:0];
		send_frame(2);
		frame_w[0] = {8'h00, `HPS_CMD_FILE_INFO};
		frame_w[1] = rand_word();
		frame_w[2] = rand_word();
		ext        = {frame_w[1], frame_w[2]};
		send_frame(3);
		frame_w[0] = {8'h00, `HPS_CMD_FILE_TX};
		frame_w[1] = 16'h00ff;
		send_frame(2);
		wait_download(1'b1);
		frame_w[0] = {8'h00, `HPS_CMD_FILE_DAT};
		for (i = 0; i < dl_words; i++) begin
			dl_data[i]   = rand_word();
			frame_w[i+1] = dl_data[i];
		end
		send_frame(dl_words + 1);
		frame_w[0] = {8'h00, `HPS_CMD_FILE_TX};
		frame_w[1] = 16'h0000;
		send_frame(2);
		wait_download(1'b0);
		wait_writes(dl_words);
		check_value("write count", wr_addr.size(), dl_words);
		check_value("dl.index", dl.index, idx);
		check_value("dl.file_ext", dl.file_ext, ext);
		for (i = 0; i < wr_addr.size() && i < dl_words; i++) begin
			check_value("dl.addr", wr_addr[i], i * addr_step);
			check_value("dl.dout", wr_data[i], (`HPS_DL_WIDE != 0) ? dl_data[i]
				: {8'h00, dl_data[i][7:0]});
		end

		tick();
		total = errors + u_hps_link_top.u_hps_link_assert.fail_cnt;
		$display("checks %0d, check errors %0d, assertion failures %0d", checks, errors,
			u_hps_link_top.u_hps_link_assert.fail_cnt);
		if (total == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* files.f */
+incdir+.
hps_link_pkg.sv
hps_frame_decoder.sv
hps_reg_block.sv
hps_key_decoder.sv
hps_file_loader.sv
hps_link_top.sv
hps_link_assert.sv
tb_hps_link.sv

/* Makefile */
# Verilator build and run for the host link testbench
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_hps_link
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= TB PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
